/* src/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// width of a data word, of an address and of an instruction byte.
`define CPU_DATA_W 8

// bytes in the unified program and data memory.
`define CPU_MEM_DEPTH 256

// a store to this address goes out on the output strobe and leaves the RAM alone.
`define CPU_IO_ADDR 8'hFF

// the stack grows downward from here, so the first PUSH lands at 8'hEF.
`define CPU_SP_INIT 8'hF0

`endif

/* src/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    // an instruction byte is {opcode[7:4], rd[3:2], rs[1:0]}.
    // LDI, JMP, CALL, LDA and STA carry a second byte with the immediate or address.
    // MOV rd <= rs. ADD, SUB and AND compute rd <= rd op rs.
    // LDI, LDA and POP load rd. STA and PUSH take their data from rd.
    // LDX loads rd from address rs, and STX stores rd at address rs.
    typedef enum logic [3:0] {
        HLT  = 4'h0,
        NOP  = 4'h1,
        MOV  = 4'h2,
        LDI  = 4'h3,
        LDX  = 4'h4,
        STX  = 4'h5,
        ADD  = 4'h6,
        SUB  = 4'h7,
        AND  = 4'h8,
        PUSH = 4'h9,
        POP  = 4'hA,
        JMP  = 4'hB,
        CALL = 4'hC,
        RET  = 4'hD,
        LDA  = 4'hE,
        STA  = 4'hF
    } opcode_t;

    typedef logic [1:0] reg_sel_t;

    typedef enum logic [1:0] {ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND} alu_op_t;

endpackage

/* src/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // control states driven from the sequencer into the datapath.
    typedef enum logic [4:0] {
        FETCH_PC,
        FETCH_INST,
        NEXT,
        HALT,
        MOV_REG,
        SET_REG,
        LOAD_ADDR,
        SET_MAR,
        SET_MEM,
        ALU_OUT,
        FETCH_SP,
        INC_SP,
        STACK_REG,
        JUMP,
        STORE_PC,
        RET,
        IDLE
    } ctrl_state_t;

    // slot of the current control state within an instruction.
    typedef enum logic [2:0] {T0, T1, T2, T3, T4, T5, T6, T7} cycle_t;

endpackage

/* src/cpu_sequencer.sv */
`timescale 1ns/1ns

module cpu_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  cpu_isa_pkg::opcode_t      opcode,
    output cpu_ctrl_pkg::ctrl_state_t state,
    output logic                      halted
);

    cpu_ctrl_pkg::cycle_t      cycle;
    cpu_ctrl_pkg::cycle_t      slot_nxt;
    cpu_ctrl_pkg::ctrl_state_t state_nxt;

    // per-slot decode table, anything not listed finishes the instruction.
    function automatic cpu_ctrl_pkg::ctrl_state_t decode(
        input cpu_ctrl_pkg::cycle_t slot,
        input cpu_isa_pkg::opcode_t op
    );
        cpu_ctrl_pkg::ctrl_state_t s;
        s = cpu_ctrl_pkg::NEXT;
        case (slot)
            cpu_ctrl_pkg::T0: s = cpu_ctrl_pkg::FETCH_PC;
            cpu_ctrl_pkg::T1: s = cpu_ctrl_pkg::FETCH_INST;
            cpu_ctrl_pkg::T2: begin
                case (op)
                    cpu_isa_pkg::HLT:  s = cpu_ctrl_pkg::HALT;
                    cpu_isa_pkg::NOP:  s = cpu_ctrl_pkg::NEXT;
                    cpu_isa_pkg::MOV:  s = cpu_ctrl_pkg::MOV_REG;
                    cpu_isa_pkg::LDI:  s = cpu_ctrl_pkg::FETCH_PC;
                    cpu_isa_pkg::LDX:  s = cpu_ctrl_pkg::LOAD_ADDR;
                    cpu_isa_pkg::STX:  s = cpu_ctrl_pkg::LOAD_ADDR;
                    cpu_isa_pkg::ADD:  s = cpu_ctrl_pkg::ALU_OUT;
                    cpu_isa_pkg::SUB:  s = cpu_ctrl_pkg::ALU_OUT;
                    cpu_isa_pkg::AND:  s = cpu_ctrl_pkg::ALU_OUT;
                    cpu_isa_pkg::PUSH: s = cpu_ctrl_pkg::FETCH_SP;
                    cpu_isa_pkg::POP:  s = cpu_ctrl_pkg::INC_SP;
                    cpu_isa_pkg::JMP:  s = cpu_ctrl_pkg::FETCH_PC;
                    cpu_isa_pkg::CALL: s = cpu_ctrl_pkg::FETCH_PC;
                    cpu_isa_pkg::RET:  s = cpu_ctrl_pkg::INC_SP;
                    cpu_isa_pkg::LDA:  s = cpu_ctrl_pkg::FETCH_PC;
                    cpu_isa_pkg::STA:  s = cpu_ctrl_pkg::FETCH_PC;
                    default:           s = cpu_ctrl_pkg::NEXT;
                endcase
            end
            cpu_ctrl_pkg::T3: begin
                case (op)
                    cpu_isa_pkg::LDI:  s = cpu_ctrl_pkg::SET_REG;
                    cpu_isa_pkg::LDX:  s = cpu_ctrl_pkg::SET_REG;
                    cpu_isa_pkg::STX:  s = cpu_ctrl_pkg::SET_MEM;
                    cpu_isa_pkg::PUSH: s = cpu_ctrl_pkg::STACK_REG;
                    cpu_isa_pkg::POP:  s = cpu_ctrl_pkg::SET_REG;
                    cpu_isa_pkg::JMP:  s = cpu_ctrl_pkg::JUMP;
                    cpu_isa_pkg::CALL: s = cpu_ctrl_pkg::SET_REG;
                    cpu_isa_pkg::RET:  s = cpu_ctrl_pkg::RET;
                    cpu_isa_pkg::LDA:  s = cpu_ctrl_pkg::SET_MAR;
                    cpu_isa_pkg::STA:  s = cpu_ctrl_pkg::SET_MAR;
                    default:           s = cpu_ctrl_pkg::NEXT;
                endcase
            end
            cpu_ctrl_pkg::T4: begin
                case (op)
                    cpu_isa_pkg::CALL: s = cpu_ctrl_pkg::FETCH_SP;
                    cpu_isa_pkg::LDA:  s = cpu_ctrl_pkg::SET_REG;
                    cpu_isa_pkg::STA:  s = cpu_ctrl_pkg::SET_MEM;
                    default:           s = cpu_ctrl_pkg::NEXT;
                endcase
            end
            cpu_ctrl_pkg::T5: begin
                if (op == cpu_isa_pkg::CALL) begin
                    s = cpu_ctrl_pkg::STORE_PC;
                end
            end
            // only CALL gets this far.
            cpu_ctrl_pkg::T6: s = cpu_ctrl_pkg::JUMP;
            default:          s = cpu_ctrl_pkg::NEXT;
        endcase
        return s;
    endfunction

    always_comb begin
        slot_nxt  = cpu_ctrl_pkg::cycle_t'(cycle + 3'd1);
        state_nxt = state;
        case (state)
            cpu_ctrl_pkg::IDLE: begin
                if (start) begin
                    state_nxt = cpu_ctrl_pkg::FETCH_PC;
                end
            end
            cpu_ctrl_pkg::HALT: state_nxt = cpu_ctrl_pkg::HALT;
            cpu_ctrl_pkg::NEXT: state_nxt = decode(cpu_ctrl_pkg::T0, opcode);
            default:            state_nxt = decode(slot_nxt, opcode);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= cpu_ctrl_pkg::IDLE;
            cycle  <= cpu_ctrl_pkg::T0;
            halted <= 1'b0;
        end else begin
            state <= state_nxt;
            // the first fetch after IDLE or NEXT sits in slot T0.
            if (state == cpu_ctrl_pkg::IDLE || state == cpu_ctrl_pkg::NEXT ||
                state == cpu_ctrl_pkg::HALT) begin
                cycle <= cpu_ctrl_pkg::T0;
            end else begin
                cycle <= slot_nxt;
            end
            if (state_nxt == cpu_ctrl_pkg::HALT) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

/* src/cpu_datapath.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_datapath (
    input  logic                      clk,
    input  logic                      rst,
    input  cpu_ctrl_pkg::ctrl_state_t state,
    input  logic [`CPU_DATA_W-1:0]    mem_rdata,
    output cpu_isa_pkg::opcode_t      opcode,
    output logic [`CPU_DATA_W-1:0]    mem_addr,
    output logic [`CPU_DATA_W-1:0]    mem_wdata,
    output logic                      mem_we
);

    logic [`CPU_DATA_W-1:0] ir;
    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] sp;
    logic [`CPU_DATA_W-1:0] mar;
    logic [`CPU_DATA_W-1:0] tmp;
    logic [`CPU_DATA_W-1:0] regs [0:3];
    cpu_isa_pkg::reg_sel_t  rd;
    cpu_isa_pkg::reg_sel_t  rs;
    cpu_isa_pkg::alu_op_t   alu_op;
    logic [`CPU_DATA_W-1:0] alu_y;

    assign rd = ir[3:2];
    assign rs = ir[1:0];

    // the sequencer decodes slot T2 on the edge that loads IR, so it sees the byte directly.
    assign opcode = (state == cpu_ctrl_pkg::FETCH_INST) ?
                    cpu_isa_pkg::opcode_t'(mem_rdata[7:4]) :
                    cpu_isa_pkg::opcode_t'(ir[7:4]);

    always_comb begin
        case (opcode)
            cpu_isa_pkg::ADD: alu_op = cpu_isa_pkg::ALU_ADD;
            cpu_isa_pkg::SUB: alu_op = cpu_isa_pkg::ALU_SUB;
            cpu_isa_pkg::AND: alu_op = cpu_isa_pkg::ALU_AND;
            default:          alu_op = cpu_isa_pkg::ALU_PASS;
        endcase
    end

    always_comb begin
        case (alu_op)
            cpu_isa_pkg::ALU_ADD: alu_y = regs[rd] + regs[rs];
            cpu_isa_pkg::ALU_SUB: alu_y = regs[rd] - regs[rs];
            cpu_isa_pkg::ALU_AND: alu_y = regs[rd] & regs[rs];
            default:              alu_y = regs[rs];
        endcase
    end

    // address defaults to MAR, which serves SET_MEM.
    always_comb begin
        mem_addr  = mar;
        mem_wdata = regs[rd];
        mem_we    = 1'b0;
        case (state)
            cpu_ctrl_pkg::FETCH_PC:  mem_addr = pc;
            cpu_ctrl_pkg::LOAD_ADDR: mem_addr = regs[rs];
            cpu_ctrl_pkg::SET_MAR:   mem_addr = mem_rdata;
            cpu_ctrl_pkg::INC_SP:    mem_addr = sp;
            cpu_ctrl_pkg::SET_MEM:   mem_we = 1'b1;
            cpu_ctrl_pkg::STACK_REG: begin
                mem_addr = sp;
                mem_we   = 1'b1;
            end
            cpu_ctrl_pkg::STORE_PC: begin
                mem_addr  = sp;
                mem_wdata = pc;
                mem_we    = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= '0;
            pc <= '0;
            sp <= `CPU_SP_INIT;
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else begin
            case (state)
                cpu_ctrl_pkg::FETCH_PC:   pc <= pc + 1'b1;
                cpu_ctrl_pkg::FETCH_INST: ir <= mem_rdata;
                cpu_ctrl_pkg::MOV_REG:    regs[rd] <= alu_y;
                cpu_ctrl_pkg::ALU_OUT:    regs[rd] <= alu_y;
                cpu_ctrl_pkg::SET_REG: begin
                    if (opcode != cpu_isa_pkg::CALL) begin
                        regs[rd] <= mem_rdata;
                    end
                end
                cpu_ctrl_pkg::FETCH_SP:   sp <= sp - 1'b1;
                cpu_ctrl_pkg::INC_SP:     sp <= sp + 1'b1;
                cpu_ctrl_pkg::JUMP:       pc <= (opcode == cpu_isa_pkg::CALL) ? tmp : mem_rdata;
                cpu_ctrl_pkg::RET:        pc <= mem_rdata;
                default: ;
            endcase
        end
    end

    // CALL parks its target in tmp while the return address goes onto the stack.
    always_ff @(posedge clk) begin
        if (state == cpu_ctrl_pkg::LOAD_ADDR) begin
            mar <= regs[rs];
        end else if (state == cpu_ctrl_pkg::SET_MAR) begin
            mar <= mem_rdata;
        end
        if (state == cpu_ctrl_pkg::SET_REG && opcode == cpu_isa_pkg::CALL) begin
            tmp <= mem_rdata;
        end
    end

endmodule

/* src/cpu_memory.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_memory (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CPU_DATA_W-1:0] addr,
    input  logic [`CPU_DATA_W-1:0] wdata,
    input  logic                   we,
    input  logic                   load_en,
    input  logic [`CPU_DATA_W-1:0] load_addr,
    input  logic [`CPU_DATA_W-1:0] load_data,
    output logic [`CPU_DATA_W-1:0] rdata,
    output logic                   out_valid,
    output logic [`CPU_DATA_W-1:0] out_data
);

    logic [`CPU_DATA_W-1:0] ram [0:`CPU_MEM_DEPTH-1];
    logic                   io_hit;

    assign io_hit = we && (addr == `CPU_IO_ADDR);

    // the load port only runs while the CPU is stopped, so it never meets a CPU write.
    always_ff @(posedge clk) begin
        if (load_en) begin
            ram[load_addr] <= load_data;
        end else if (we && !io_hit) begin
            ram[addr] <= wdata;
        end
        rdata <= ram[addr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= io_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (io_hit) begin
            out_data <= wdata;
        end
    end

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_en,
    input  logic [`CPU_DATA_W-1:0] load_addr,
    input  logic [`CPU_DATA_W-1:0] load_data,
    input  logic                   start,
    output logic                   out_valid,
    output logic [`CPU_DATA_W-1:0] out_data,
    output logic                   halted
);

    cpu_ctrl_pkg::ctrl_state_t state;
    cpu_isa_pkg::opcode_t      opcode;
    logic [`CPU_DATA_W-1:0]    mem_addr;
    logic [`CPU_DATA_W-1:0]    mem_wdata;
    logic [`CPU_DATA_W-1:0]    mem_rdata;
    logic                      mem_we;
    logic                      load_ok;

    // program loads are dropped while an instruction is in flight.
    assign load_ok = load_en && (halted || state == cpu_ctrl_pkg::IDLE);

    cpu_sequencer seq0 (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .opcode (opcode),
        .state  (state),
        .halted (halted)
    );

    cpu_datapath dp0 (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .mem_rdata (mem_rdata),
        .opcode    (opcode),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we)
    );

    cpu_memory mem0 (
        .clk       (clk),
        .rst       (rst),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .we        (mem_we),
        .load_en   (load_ok),
        .load_addr (load_addr),
        .load_data (load_data),
        .rdata     (mem_rdata),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

/* tb/cpu_clock_gen.sv */
`timescale 1ns/1ns

module cpu_clock_gen (
    input  logic reset_req,
    output logic clk,
    output logic rst
);

    // reset is held while this counts down from 4.
    int unsigned hold = 4;

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (reset_req) begin
            hold <= 4;
        end else if (hold != 0) begin
            hold <= hold - 1;
        end
    end

    assign rst = (hold != 0);

endmodule

/* tb/cpu_properties.sv */
`timescale 1ns/1ns

module cpu_properties (
    input logic                      clk,
    input logic                      rst,
    input cpu_ctrl_pkg::ctrl_state_t state,
    input cpu_ctrl_pkg::cycle_t      cycle,
    input logic                      halted
);

    // IDLE is the last member, so every encoding above it is unused.
    state_legal: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state) && state <= cpu_ctrl_pkg::IDLE)
        else $error("sequencer state %0d is outside the control-state set", state);

    halted_sticky: assert property (@(posedge clk)
        $fell(halted) |-> $past(rst))
        else $error("halted dropped while reset was low");

    slot_cleared: assert property (@(posedge clk) disable iff (rst)
        state == cpu_ctrl_pkg::NEXT |=> cycle == cpu_ctrl_pkg::T0)
        else $error("cycle slot did not return to T0 after NEXT");

endmodule

/* tb/cpu_tb.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_tb;

    logic       clk;
    logic       rst;
    logic       reset_req;
    logic       load_en;
    logic [7:0] load_addr;
    logic [7:0] load_data;
    logic       start;
    logic       out_valid;
    logic [7:0] out_data;
    logic       halted;

    logic [7:0] image [0:255];
    logic [7:0] asm_pc;
    logic [7:0] expect_q [$];
    logic [7:0] want;
    int         value_errors;
    int         other_errors;
    int         checks;
    bit         timed_out;

    cpu_clock_gen clkgen0 (
        .reset_req (reset_req),
        .clk       (clk),
        .rst       (rst)
    );

    cpu_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted)
    );

    bind cpu_sequencer cpu_properties props0 (
        .clk    (clk),
        .rst    (rst),
        .state  (state),
        .cycle  (cycle),
        .halted (halted)
    );

    task automatic emit(input logic [7:0] b);
        image[asm_pc] = b;
        asm_pc = asm_pc + 8'd1;
    endtask

    task automatic emit_op(input cpu_isa_pkg::opcode_t op, input logic [1:0] rd,
                           input logic [1:0] rs);
        emit({op, rd, rs});
    endtask

    task automatic emit_imm(input cpu_isa_pkg::opcode_t op, input logic [1:0] rd,
                            input logic [7:0] imm);
        emit({op, rd, 2'b00});
        emit(imm);
    endtask

    // unused bytes get a value that changes with every address bit.
    task automatic clear_image();
        for (int a = 0; a < 256; a++) begin
            image[8'(a)] = 8'(a * 37) ^ 8'h5C;
        end
        asm_pc = 8'h00;
    endtask

    // interprets the loaded image and fills expect_q with every byte stored to the I/O address.
    function automatic int reference_run();
        logic [7:0] m [0:255];
        logic [7:0] r [0:3];
        logic [7:0] pc;
        logic [7:0] sp;
        logic [7:0] ins;
        logic [7:0] arg;
        logic [7:0] wa;
        logic [7:0] wd;
        logic [1:0] rd;
        logic [1:0] rs;
        bit         wr;
        bit         done;
        int         n;
        for (int a = 0; a < 256; a++) begin
            m[8'(a)] = image[8'(a)];
        end
        for (int i = 0; i < 4; i++) begin
            r[2'(i)] = 8'h00;
        end
        pc = 8'h00;
        sp = `CPU_SP_INIT;
        n = 0;
        done = 1'b0;
        expect_q.delete();
        while (!done && n < 2000) begin
            ins = m[pc];
            pc = pc + 8'd1;
            rd = ins[3:2];
            rs = ins[1:0];
            wr = 1'b0;
            wa = 8'h00;
            wd = 8'h00;
            n++;
            case (ins[7:4])
                cpu_isa_pkg::HLT: done = 1'b1;
                cpu_isa_pkg::MOV: r[rd] = r[rs];
                cpu_isa_pkg::LDI: begin
                    r[rd] = m[pc];
                    pc = pc + 8'd1;
                end
                cpu_isa_pkg::LDX: r[rd] = m[r[rs]];
                cpu_isa_pkg::STX: begin
                    wr = 1'b1;
                    wa = r[rs];
                    wd = r[rd];
                end
                cpu_isa_pkg::ADD: r[rd] = r[rd] + r[rs];
                cpu_isa_pkg::SUB: r[rd] = r[rd] - r[rs];
                cpu_isa_pkg::AND: r[rd] = r[rd] & r[rs];
                cpu_isa_pkg::PUSH: begin
                    sp = sp - 8'd1;
                    wr = 1'b1;
                    wa = sp;
                    wd = r[rd];
                end
                cpu_isa_pkg::POP: begin
                    r[rd] = m[sp];
                    sp = sp + 8'd1;
                end
                cpu_isa_pkg::JMP: pc = m[pc];
                cpu_isa_pkg::CALL: begin
                    arg = m[pc];
                    pc = pc + 8'd1;
                    sp = sp - 8'd1;
                    wr = 1'b1;
                    wa = sp;
                    wd = pc;
                    pc = arg;
                end
                cpu_isa_pkg::RET: begin
                    pc = m[sp];
                    sp = sp + 8'd1;
                end
                cpu_isa_pkg::LDA: begin
                    r[rd] = m[m[pc]];
                    pc = pc + 8'd1;
                end
                cpu_isa_pkg::STA: begin
                    wr = 1'b1;
                    wa = m[pc];
                    wd = r[rd];
                    pc = pc + 8'd1;
                end
                default: ;
            endcase
            if (wr && wa == `CPU_IO_ADDR) begin
                expect_q.push_back(wd);
            end else if (wr) begin
                m[wa] = wd;
            end
        end
        return n;
    endfunction

    task automatic build_random();
        logic [1:0] a;
        logic [1:0] b;
        int         kind;
        for (int i = 0; i < 4; i++) begin
            emit_imm(cpu_isa_pkg::LDI, 2'(i), 8'($urandom));
        end
        for (int i = 0; i < 16; i++) begin
            kind = int'($urandom_range(0, 6));
            a = 2'($urandom);
            b = 2'($urandom);
            case (kind)
                0: emit_imm(cpu_isa_pkg::LDI, a, 8'($urandom));
                1: emit_op(cpu_isa_pkg::MOV, a, b);
                2: emit_op(cpu_isa_pkg::ADD, a, b);
                3: emit_op(cpu_isa_pkg::SUB, a, b);
                4: emit_op(cpu_isa_pkg::AND, a, b);
                5: emit_imm(cpu_isa_pkg::STA, a, `CPU_IO_ADDR);
                default: begin
                    emit_op(cpu_isa_pkg::PUSH, a, 2'd0);
                    emit_op(cpu_isa_pkg::POP, b, 2'd0);
                end
            endcase
        end
        for (int i = 0; i < 4; i++) begin
            emit_imm(cpu_isa_pkg::STA, 2'(i), `CPU_IO_ADDR);
        end
        emit_op(cpu_isa_pkg::HLT, 2'd0, 2'd0);
    endtask

    task automatic build_program(input int c);
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] ad;
        clear_image();
        case (c)
            0: begin
                emit_imm(cpu_isa_pkg::LDI, 2'd1, 8'($urandom));
                emit_imm(cpu_isa_pkg::STA, 2'd1, `CPU_IO_ADDR);
                emit_op(cpu_isa_pkg::HLT, 2'd0, 2'd0);
            end
            1: begin
                for (int k = 0; k < 3; k++) begin
                    x = 8'($urandom);
                    y = 8'($urandom);
                    // first pass carries out of ADD, second borrows in SUB.
                    if (k == 0) begin
                        x = x | 8'h80;
                        y = y | 8'h80;
                    end else if (k == 1) begin
                        x = x & 8'h7F;
                        y = y | 8'h80;
                    end
                    emit_imm(cpu_isa_pkg::LDI, 2'd0, x);
                    emit_imm(cpu_isa_pkg::LDI, 2'd1, y);
                    emit_op(cpu_isa_pkg::MOV, 2'd2, 2'd0);
                    emit_op(cpu_isa_pkg::ADD, 2'd2, 2'd1);
                    emit_imm(cpu_isa_pkg::STA, 2'd2, `CPU_IO_ADDR);
                    emit_op(cpu_isa_pkg::MOV, 2'd3, 2'd0);
                    emit_op(cpu_isa_pkg::SUB, 2'd3, 2'd1);
                    emit_imm(cpu_isa_pkg::STA, 2'd3, `CPU_IO_ADDR);
                    emit_op(cpu_isa_pkg::AND, 2'd0, 2'd1);
                    emit_imm(cpu_isa_pkg::STA, 2'd0, `CPU_IO_ADDR);
                    emit_op(cpu_isa_pkg::MOV, 2'd3, 2'd1);
                    emit_imm(cpu_isa_pkg::STA, 2'd3, `CPU_IO_ADDR);
                end
                emit_op(cpu_isa_pkg::HLT, 2'd0, 2'd0);
            end
            2: begin
                ad = 8'h80 + 8'($urandom_range(0, 63));
                x = 8'($urandom);
                emit_imm(cpu_isa_pkg::LDI, 2'd0, ad);
                emit_imm(cpu_isa_pkg::LDI, 2'd1, x);
                emit_op(cpu_isa_pkg::STX, 2'd1, 2'd0);
                emit_op(cpu_isa_pkg::LDX, 2'd2, 2'd0);
                emit_imm(cpu_isa_pkg::STA, 2'd2, `CPU_IO_ADDR);
                ad = 8'hC0 + 8'($urandom_range(0, 31));
                emit_imm(cpu_isa_pkg::LDI, 2'd3, ~x);
                emit_imm(cpu_isa_pkg::STA, 2'd3, ad);
                emit_imm(cpu_isa_pkg::LDA, 2'd1, ad);
                emit_imm(cpu_isa_pkg::STA, 2'd1, `CPU_IO_ADDR);
                emit_imm(cpu_isa_pkg::LDI, 2'd0, `CPU_IO_ADDR);
                emit_op(cpu_isa_pkg::STX, 2'd2, 2'd0);
                emit_op(cpu_isa_pkg::HLT, 2'd0, 2'd0);
            end
            3: begin
                for (int i = 0; i < 3; i++) begin
                    emit_imm(cpu_isa_pkg::LDI, 2'(i), 8'($urandom));
                end
                for (int i = 0; i < 3; i++) begin
                    emit_op(cpu_isa_pkg::PUSH, 2'(i), 2'd0);
                end
                for (int i = 0; i < 3; i++) begin
                    emit_op(cpu_isa_pkg::POP, 2'd3, 2'd0);
                    emit_imm(cpu_isa_pkg::STA, 2'd3, `CPU_IO_ADDR);
                end
                emit_imm(cpu_isa_pkg::CALL, 2'd0, 8'h40);
                emit_imm(cpu_isa_pkg::LDI, 2'd1, 8'($urandom));
                emit_imm(cpu_isa_pkg::STA, 2'd1, `CPU_IO_ADDR);
                emit_op(cpu_isa_pkg::HLT, 2'd0, 2'd0);
                asm_pc = 8'h40;
                emit_imm(cpu_isa_pkg::LDI, 2'd0, 8'($urandom));
                emit_imm(cpu_isa_pkg::STA, 2'd0, `CPU_IO_ADDR);
                emit_op(cpu_isa_pkg::RET, 2'd0, 2'd0);
            end
            4: begin
                emit_imm(cpu_isa_pkg::LDI, 2'd0, 8'($urandom));
                emit_op(cpu_isa_pkg::NOP, 2'd0, 2'd0);
                // the target lands just past the STA that follows the JMP.
                emit_imm(cpu_isa_pkg::JMP, 2'd0, asm_pc + 8'd4);
                emit_imm(cpu_isa_pkg::STA, 2'd0, `CPU_IO_ADDR);
                emit_imm(cpu_isa_pkg::LDI, 2'd1, 8'($urandom));
                emit_imm(cpu_isa_pkg::STA, 2'd1, `CPU_IO_ADDR);
                emit_op(cpu_isa_pkg::HLT, 2'd0, 2'd0);
                emit_imm(cpu_isa_pkg::STA, 2'd0, `CPU_IO_ADDR);
            end
            default: build_random();
        endcase
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
    endtask

    task automatic idle_check();
        checks++;
        if (halted !== 1'b0) begin
            $display("Fail at %0t ns: halted = %b, expected 0", $time, halted);
            value_errors++;
        end
        if (out_valid !== 1'b0) begin
            $display("Fail at %0t ns: out_valid = %b, expected 0", $time, out_valid);
            value_errors++;
        end
    endtask

    task automatic load_image();
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= 8'(a);
            load_data <= image[8'(a)];
            idle_check();
        end
        @(posedge clk);
        load_en <= 1'b0;
        idle_check();
    endtask

    task automatic run_program(input int c);
        int n;
        int limit;
        int cycles;
        n = reference_run();
        limit = 40 * n + 200;
        apply_reset();
        load_image();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        while (halted !== 1'b1 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("Timeout: program %0d did not halt within %0d cycles", c, limit);
            other_errors++;
            timed_out = 1'b1;
        end else begin
            repeat (20) begin
                @(posedge clk);
                checks++;
                if (halted !== 1'b1) begin
                    $display("Fail at %0t ns: halted = %b, expected 1", $time, halted);
                    value_errors++;
                end
            end
            if (expect_q.size() != 0) begin
                $display("Error: program %0d halted with %0d expected output bytes never sent",
                         c, expect_q.size());
                other_errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst && out_valid === 1'b1) begin
            checks++;
            if (expect_q.size() == 0) begin
                $display("Error: output byte %02h at %0t ns was not expected", out_data, $time);
                other_errors++;
            end else begin
                want = expect_q.pop_front();
                if (out_data !== want) begin
                    $display("Fail at %0t ns: out_data = %02h, expected %02h",
                             $time, out_data, want);
                    value_errors++;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h2c32c47f));
        reset_req    = 1'b0;
        load_en      = 1'b0;
        load_addr    = 8'h00;
        load_data    = 8'h00;
        start        = 1'b0;
        value_errors = 0;
        other_errors = 0;
        checks       = 0;
        timed_out    = 1'b0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        // programs 5 and 6 are random and each runs after its own reset and reload.
        for (int c = 0; c < 7 && !timed_out; c++) begin
            build_program(c);
            run_program(c);
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+src
src/cpu_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/cpu_sequencer.sv
src/cpu_datapath.sv
src/cpu_memory.sv
src/cpu_top.sv
tb/cpu_clock_gen.sv
tb/cpu_properties.sv
tb/cpu_tb.sv

/* Makefile */
TOOL    := verilator
TOP     := cpu_tb
FLIST   := compile.f
FLAGS   := --binary --timing --assert -Wno-fatal
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
